//--- design/ac97_pkg.sv
`default_nettype none

package ac97_pkg;

  //////////////////////////////
  // widths with a meaning
  //////////////////////////////

  typedef logic [7:0]  frame_bit_t;
  // left-justified two's complement
  typedef logic [19:0] pcm_sample_t;
  // top byte of a pcm sample
  typedef logic [7:0]  user_sample_t;
  typedef logic [4:0]  volume_t;
  typedef logic [7:0]  reg_address_t;
  typedef logic [15:0] reg_data_t;

  typedef struct packed {
    reg_address_t address;
    reg_data_t    data;
    logic         valid;
  } ac97_command_t;

  typedef struct packed {
    pcm_sample_t left;
    pcm_sample_t right;
  } stereo_sample_t;

  //////////////////////////////
  // frame layout
  //////////////////////////////

  localparam frame_bit_t synch_end_bit   = 8'd15;
  localparam frame_bit_t slot1_first     = 8'd16;
  localparam frame_bit_t slot2_first     = 8'd36;
  localparam frame_bit_t slot3_first     = 8'd56;
  localparam frame_bit_t slot4_first     = 8'd76;
  localparam frame_bit_t slot4_last      = 8'd95;
  localparam frame_bit_t ready_set_bit   = 8'd128;
  localparam frame_bit_t ready_clear_bit = 8'd2;
  localparam frame_bit_t frame_last_bit  = 8'd255;

  // mic input on the record mux
  localparam logic [2:0] record_source_mic = 3'd0;
  localparam volume_t volume_reset_level = 5'd8;

  // codec register commands, address in 23:16
  localparam logic [23:0] cmd_read_id         = 24'h80_0000;
  localparam logic [23:0] cmd_pcm_volume      = 24'h18_0808;
  localparam logic [23:0] cmd_record_gain_max = 24'h1C_0F0F;
  localparam logic [23:0] cmd_mic_boost       = 24'h0E_8048;
  localparam logic [23:0] cmd_beep_volume     = 24'h0A_0000;
  localparam logic [23:0] cmd_bypass_mix      = 24'h20_8000;

  localparam reg_address_t reg_headphone_volume = 8'h04;
  localparam reg_address_t reg_record_select    = 8'h1A;

  // one sine period, 64 points
  localparam pcm_sample_t sine_table [64] = '{
    20'h00000, 20'h0C8BD, 20'h18F8B, 20'h25280, 20'h30FBC, 20'h3C56B, 20'h471CE, 20'h5133C,
    20'h5A827, 20'h62F20, 20'h6A6D9, 20'h70E2C, 20'h7641A, 20'h7A7D0, 20'h7D8A5, 20'h7F623,
    20'h7FFFF, 20'h7F623, 20'h7D8A5, 20'h7A7D0, 20'h7641A, 20'h70E2C, 20'h6A6D9, 20'h62F20,
    20'h5A827, 20'h5133C, 20'h471CE, 20'h3C56B, 20'h30FBC, 20'h25280, 20'h18F8B, 20'h0C8BD,
    20'h00000, 20'hF3743, 20'hE7075, 20'hDAD80, 20'hCF044, 20'hC3A95, 20'hB8E32, 20'hAECC4,
    20'hA57D9, 20'h9D0E0, 20'h95927, 20'h8F1D4, 20'h89BE6, 20'h85830, 20'h8275B, 20'h809DD,
    20'h80000, 20'h809DD, 20'h8275B, 20'h85830, 20'h89BE6, 20'h8F1D4, 20'h95927, 20'h9D0E0,
    20'hA57D9, 20'hAECC4, 20'hB8E32, 20'hC3A95, 20'hCF044, 20'hDAD80, 20'hE7075, 20'hF3743
  };

endpackage

`default_nettype wire

//--- design/ac97_framer.sv
`timescale 1ns/1ns
`default_nettype none

module ac97_framer import ac97_pkg::*; (
  input  logic           ac97_bit_clock,
  input  ac97_command_t  command,
  input  stereo_sample_t playback,
  output stereo_sample_t capture,
  output logic           frame_ready,
  output logic           ac97_sdata_out,
  input  logic           ac97_sdata_in,
  output logic           ac97_synch
);

  // free-running, bit clock domain has no reset
  frame_bit_t bit_count = '0;

  logic synch_q = 1'b0;
  logic ready_q = 1'b0;
  logic sdata_q = 1'b0;

  // latched once per frame at the last bit
  ac97_command_t  cmd_q;
  stereo_sample_t play_q;

  stereo_sample_t capture_q = '0;

  logic [19:0] cmd_address_slot;
  logic [19:0] cmd_data_slot;
  logic [4:0]  slot_index;
  logic        sdata_next;

  // address and data sit left-justified in 20-bit slots
  assign cmd_address_slot = {cmd_q.address, 12'h000};
  assign cmd_data_slot    = {cmd_q.data, 4'h0};

  //////////////////////////////
  // outgoing bit select
  //////////////////////////////

  always_comb begin
    slot_index = '0;
    sdata_next = 1'b0;
    if (bit_count <= synch_end_bit) begin
      // slot 0 tags
      case (bit_count[3:0])
        // frame valid
        4'd0: sdata_next = 1'b1;
        // command address and data valid
        4'd1, 4'd2: sdata_next = cmd_q.valid;
        // left and right always carry audio
        4'd3, 4'd4: sdata_next = 1'b1;
        default: sdata_next = 1'b0;
      endcase
    end else if (bit_count < slot2_first) begin
      // slot 1, command address, msb first
      slot_index = 5'(slot2_first - 8'd1 - bit_count);
      sdata_next = cmd_q.valid & cmd_address_slot[slot_index];
    end else if (bit_count < slot3_first) begin
      // slot 2, command data
      slot_index = 5'(slot3_first - 8'd1 - bit_count);
      sdata_next = cmd_q.valid & cmd_data_slot[slot_index];
    end else if (bit_count < slot4_first) begin
      // slot 3, left pcm
      slot_index = 5'(slot4_first - 8'd1 - bit_count);
      sdata_next = play_q.left[slot_index];
    end else if (bit_count <= slot4_last) begin
      // slot 4, right pcm
      slot_index = 5'(slot4_last - bit_count);
      sdata_next = play_q.right[slot_index];
    end
  end

  //////////////////////////////
  // frame timing, rising edge
  //////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    bit_count <= bit_count + 8'd1;
    sdata_q   <= sdata_next;

    // synch covers slot 0, one bit early since registered
    if (bit_count == frame_last_bit) begin
      synch_q <= 1'b1;
    end else if (bit_count == synch_end_bit) begin
      synch_q <= 1'b0;
    end

    // ready window kept clear of the latch point
    if (bit_count == ready_set_bit) begin
      ready_q <= 1'b1;
    end else if (bit_count == ready_clear_bit) begin
      ready_q <= 1'b0;
    end

    // first frame after startup goes out empty
    if (bit_count == frame_last_bit) begin
      cmd_q  <= command;
      play_q <= playback;
    end
  end

  // codec drives on rising edge, sample on falling
  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count > slot3_first && bit_count <= slot4_first) begin
      capture_q.left <= {capture_q.left[18:0], ac97_sdata_in};
    end else if (bit_count > slot4_first && bit_count <= slot4_last + 8'd1) begin
      capture_q.right <= {capture_q.right[18:0], ac97_sdata_in};
    end
  end

  assign ac97_synch     = synch_q;
  assign frame_ready    = ready_q;
  assign ac97_sdata_out = sdata_q;
  assign capture        = capture_q;

  // synch spans exactly the 16 tag bits
  assert property (@(posedge ac97_bit_clock)
    $rose(synch_q) |-> synch_q [*16] ##1 !synch_q);

endmodule

`default_nettype wire

//--- design/ac97_command_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module ac97_command_sequencer import ac97_pkg::*; (
  input  logic          clock_27mhz,
  input  logic          reset,
  input  logic          ready,
  input  volume_t       volume,
  output ac97_command_t command
);

  typedef enum logic [3:0] {
    step_read_id0,
    step_read_id1,
    step_idle2,
    step_headphone,
    step_idle4,
    step_pcm_volume,
    step_record_select,
    step_record_gain,
    step_idle8,
    step_mic_boost,
    step_beep_volume,
    step_bypass_mix,
    step_idle12,
    step_idle13,
    step_idle14,
    step_idle15
  } step_t;

  step_t       step;
  volume_t     attenuation;
  logic [23:0] next_pair;

  // codec volume fields are attenuation
  assign attenuation = 5'd31 - volume;

  //////////////////////////////
  // command per step
  //////////////////////////////

  always_comb begin
    case (step)
      step_headphone:
        next_pair = {reg_headphone_volume, 3'b000, attenuation, 3'b000, attenuation};
      step_pcm_volume:
        next_pair = cmd_pcm_volume;
      // same source on both channels
      step_record_select:
        next_pair = {reg_record_select, 5'b00000, record_source_mic,
                     5'b00000, record_source_mic};
      step_record_gain:
        next_pair = cmd_record_gain_max;
      // +20 dB mic boost
      step_mic_boost:
        next_pair = cmd_mic_boost;
      step_beep_volume:
        next_pair = cmd_beep_volume;
      step_bypass_mix:
        next_pair = cmd_bypass_mix;
      // read id fills the gaps
      default:
        next_pair = cmd_read_id;
    endcase
  end

  // one step per frame, wraps after 16
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      step    <= step_read_id0;
      command <= '0;
    end else begin
      if (ready) begin
        step <= step_t'(step + 4'd1);
      end
      command.address <= next_pair[23:16];
      command.data    <= next_pair[15:0];
      command.valid   <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/ac97_sample_port.sv
`timescale 1ns/1ns
`default_nettype none

module ac97_sample_port import ac97_pkg::*; (
  input  logic           clock_27mhz,
  input  logic           reset,
  input  logic           frame_ready,
  input  stereo_sample_t capture,
  input  pcm_sample_t    tone_sample,
  input  logic           tone_select,
  input  user_sample_t   audio_out_data,
  output stereo_sample_t playback,
  output user_sample_t   audio_in_data,
  output logic           ready
);

  // bit clock level into clock_27mhz
  logic [2:0]  ready_sync;
  pcm_sample_t next_sample;
  pcm_sample_t held_sample;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[1:0], frame_ready};
    end
  end

  // rising edge past the first two stages
  assign ready = ready_sync[1] & ~ready_sync[2];

  //////////////////////////////
  // playback sample
  //////////////////////////////

  // user byte padded out to 20 bits
  assign next_sample = tone_select ? tone_sample : {audio_out_data, 12'h000};

  always_ff @(posedge clock_27mhz) begin
    if (ready) begin
      held_sample <= next_sample;
    end
  end

  // mono source on both channels
  assign playback.left  = held_sample;
  assign playback.right = held_sample;

  // capture is mono, left channel only
  assign audio_in_data = capture.left[19:12];

endmodule

`default_nettype wire

//--- design/volume_control.sv
`timescale 1ns/1ns
`default_nettype none

module volume_control import ac97_pkg::*; (
  input  logic    clock_27mhz,
  input  logic    reset,
  input  logic    volume_up,
  input  logic    volume_down,
  output volume_t volume
);

  localparam volume_t volume_max = 5'd31;

  logic up_q;
  logic down_q;
  logic up_edge;
  logic down_edge;

  assign up_edge   = volume_up & ~up_q;
  assign down_edge = volume_down & ~down_q;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      up_q   <= 1'b0;
      down_q <= 1'b0;
      volume <= volume_reset_level;
    end else begin
      up_q   <= volume_up;
      down_q <= volume_down;
      // down wins when both edges land together
      if (down_edge && volume != '0) begin
        volume <= volume - 5'd1;
      end else if (up_edge && volume != volume_max) begin
        volume <= volume + 5'd1;
      end
    end
  end

  // saturate at both ends
  assert property (@(posedge clock_27mhz) disable iff (reset)
    (volume == volume_max) |=> (volume != '0));
  assert property (@(posedge clock_27mhz) disable iff (reset)
    (volume == '0) |=> (volume != volume_max));

endmodule

`default_nettype wire

//--- design/tone_generator.sv
`timescale 1ns/1ns
`default_nettype none

module tone_generator import ac97_pkg::*; (
  input  logic        clock_27mhz,
  input  logic        reset,
  input  logic        ready,
  output pcm_sample_t tone_sample
);

  //////////////////////////////
  // 750 Hz at 48 kHz frames
  //////////////////////////////

  // 64 points per period, wraps by itself
  logic [5:0] index;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      index <= '0;
    end else if (ready) begin
      index <= index + 6'd1;
    end
  end

  // table lookup, held by sample port on ready
  assign tone_sample = sine_table[index];

endmodule

`default_nettype wire

//--- design/ac97_audio_top.sv
`timescale 1ns/1ns
`default_nettype none

module ac97_audio_top import ac97_pkg::*; #(
  parameter int reset_delay_cycles = 1024
) (
  input  logic         clock_27mhz,
  input  logic         reset,
  input  logic         volume_up,
  input  logic         volume_down,
  input  logic         tone_select,
  input  user_sample_t audio_out_data,
  output user_sample_t audio_in_data,
  output logic         ready,
  output logic         audio_reset_b,
  output logic         ac97_sdata_out,
  input  logic         ac97_sdata_in,
  output logic         ac97_synch,
  input  logic         ac97_bit_clock
);

  localparam int delay_width = $clog2(reset_delay_cycles + 1);

  logic [delay_width-1:0] delay_count;

  ac97_command_t  command;
  stereo_sample_t playback;
  stereo_sample_t capture;
  logic           frame_ready;
  volume_t        volume;
  pcm_sample_t    tone_sample;

  //////////////////////////////
  // codec reset delay
  //////////////////////////////

  // codec held in reset until the count runs out
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      delay_count   <= '0;
      audio_reset_b <= 1'b0;
    end else if (delay_count == delay_width'(reset_delay_cycles - 1)) begin
      audio_reset_b <= 1'b1;
    end else begin
      delay_count <= delay_count + 1'b1;
    end
  end

  // once released the codec stays out of reset
  assert property (@(posedge clock_27mhz) disable iff (reset)
    audio_reset_b |=> audio_reset_b);

  ac97_framer framer0 (
    .ac97_bit_clock (ac97_bit_clock),
    .command        (command),
    .playback       (playback),
    .capture        (capture),
    .frame_ready    (frame_ready),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch)
  );

  ac97_sample_port sample_port0 (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .frame_ready    (frame_ready),
    .capture        (capture),
    .tone_sample    (tone_sample),
    .tone_select    (tone_select),
    .audio_out_data (audio_out_data),
    .playback       (playback),
    .audio_in_data  (audio_in_data),
    .ready          (ready)
  );

  ac97_command_sequencer sequencer0 (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .ready       (ready),
    .volume      (volume),
    .command     (command)
  );

  volume_control volume0 (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .volume_up   (volume_up),
    .volume_down (volume_down),
    .volume      (volume)
  );

  tone_generator tone0 (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .ready       (ready),
    .tone_sample (tone_sample)
  );

endmodule

`default_nettype wire

//--- testbench/tb_ac97_audio.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ac97_audio import ac97_pkg::*; ();

  typedef struct packed {
    logic [3:0]  step;
    logic [23:0] pair;
    pcm_sample_t sample;
  } expected_frame_t;

  localparam int frames_to_check = 40;
  // right-shift galois taps, maximal length
  localparam logic [31:0] lfsr_taps = 32'hB4BCD35C;

  logic         clock_27mhz;
  logic         ac97_bit_clock;
  logic         reset;
  logic         volume_up;
  logic         volume_down;
  logic         tone_select;
  user_sample_t audio_out_data;
  user_sample_t audio_in_data;
  logic         ready;
  logic         audio_reset_b;
  logic         ac97_sdata_out;
  logic         ac97_sdata_in;
  logic         ac97_synch;

  logic [31:0] lfsr_state = 32'd79081;
  int          test_errors [1:6] = '{default: 0};
  string       test_names [1:6] = '{"codec reset delay", "frame timing", "command list",
                                    "headphone volume", "playback slots", "capture data"};

  // reference model, one entry per ready pulse
  expected_frame_t expected_q [$];
  logic [3:0]      model_step = 4'd0;
  logic [5:0]      model_tone_index = 6'd0;
  volume_t         model_volume = 5'd8;
  logic            hit_top = 1'b0;
  logic            hit_bottom = 1'b0;
  int              pulses = 0;
  int              frames_checked = 0;

  // codec model state
  int          frame_pos = -1000;
  int          synch_period = 0;
  int          synch_high = 0;
  int          synch_rises = 0;
  logic        synch_prev = 1'b0;
  logic [95:0] frame_shift = '0;
  pcm_sample_t codec_left = '0;
  pcm_sample_t codec_right = '0;

  initial begin
    clock_27mhz = 1'b0;
    forever #50 clock_27mhz = ~clock_27mhz;
  end

  initial begin
    ac97_bit_clock = 1'b0;
    forever #40 ac97_bit_clock = ~ac97_bit_clock;
  end

  ac97_audio_top #(.reset_delay_cycles(1024)) dut0 (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .volume_up      (volume_up),
    .volume_down    (volume_down),
    .tone_select    (tone_select),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .ready          (ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch),
    .ac97_bit_clock (ac97_bit_clock)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ lfsr_taps;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  // address and data the codec should see for a step
  function automatic logic [23:0] expected_pair(input logic [3:0] step, input volume_t volume);
    volume_t attenuation;
    attenuation = 5'd31 - volume;
    case (step)
      4'd3:    return {8'h04, 3'b000, attenuation, 3'b000, attenuation};
      4'd5:    return 24'h18_0808;
      4'd6:    return {8'h1A, 5'b00000, record_source_mic, 5'b00000, record_source_mic};
      4'd7:    return 24'h1C_0F0F;
      4'd9:    return 24'h0E_8048;
      4'd10:   return 24'h0A_0000;
      4'd11:   return 24'h20_8000;
      default: return 24'h80_0000;
    endcase
  endfunction

  task automatic report_mismatch(input int test, input string message);
    $display("MISMATCH at %0t ns, test %0d: %s", $time, test, message);
    test_errors[test]++;
  endtask

  task automatic report_failure(input int test, input string message);
    $display("test %0d failed at %0t ns: %s", test, $time, message);
    test_errors[test]++;
  endtask

  // saturating counter, the volume rule
  task automatic step_volume_model(input logic go_up);
    if (go_up) begin
      if (model_volume == 5'd31) hit_top = 1'b1;
      else model_volume = model_volume + 5'd1;
    end else begin
      if (model_volume == 5'd0) hit_bottom = 1'b1;
      else model_volume = model_volume - 5'd1;
    end
  endtask

  // slots 0 to 4 of one frame against the model
  task automatic check_frame();
    expected_frame_t expected;
    logic [19:0]     slot1;
    logic [19:0]     slot2;
    logic [19:0]     slot3;
    logic [19:0]     slot4;
    slot1 = frame_shift[79:60];
    slot2 = frame_shift[59:40];
    slot3 = frame_shift[39:20];
    slot4 = frame_shift[19:0];
    if (expected_q.size() == 0) begin
      report_failure(2, "a frame arrived with no ready pulse before it");
      return;
    end
    if (expected_q.size() != 1) begin
      report_failure(2, $sformatf("%0d ready pulses within one frame", expected_q.size()));
    end
    expected = expected_q.pop_front();
    if (frame_shift[95:80] != 16'hF800) begin
      report_mismatch(3, $sformatf("slot 0 tags %h, expected f800", frame_shift[95:80]));
    end
    if (slot1 != {expected.pair[23:16], 12'h000}) begin
      report_mismatch(3, $sformatf("step %0d address slot %h", expected.step, slot1));
    end
    if (slot2 != {expected.pair[15:0], 4'h0}) begin
      report_mismatch(expected.step == 4'd3 ? 4 : 3, $sformatf("step %0d data slot %h, expected %h",
                      expected.step, slot2, {expected.pair[15:0], 4'h0}));
    end
    if (slot3 != expected.sample || slot4 != expected.sample) begin
      report_mismatch(5, $sformatf("slots 3/4 %h %h, expected %h", slot3, slot4, expected.sample));
    end
    if (audio_in_data != codec_left[19:12]) begin
      report_mismatch(6, $sformatf("audio_in_data %h, expected %h", audio_in_data, codec_left[19:12]));
    end
    frames_checked++;
  endtask

  //////////////////////////////
  // codec model
  //////////////////////////////

  // frame_pos tracks the framer count seen at the falling edge
  always @(negedge ac97_bit_clock) begin
    if (ac97_synch === 1'b1 && !synch_prev) begin
      if (synch_rises > 0 && (synch_period != 256 || synch_high != 16)) begin
        report_mismatch(2, $sformatf("synch high %0d of %0d bit clocks", synch_high, synch_period));
      end
      synch_rises++;
      synch_period = 0;
      synch_high = 0;
      frame_pos = 0;
    end else begin
      frame_pos++;
    end
    synch_period++;
    if (ac97_synch === 1'b1) synch_high++;
    synch_prev = (ac97_synch === 1'b1);
    // bit of count frame_pos - 1 is on the line
    if (frame_pos >= 1 && frame_pos <= 96) begin
      frame_shift = {frame_shift[94:0], ac97_sdata_out};
    end
    if (frame_pos == 96) check_frame();
  end

  // drive slots 3 and 4 on the rising edge, msb first
  always @(posedge ac97_bit_clock) begin
    int next_pos;
    next_pos = frame_pos + 1;
    if (next_pos == 56) begin
      codec_left = pcm_sample_t'(take_bits(20));
      codec_right = pcm_sample_t'(take_bits(20));
    end
    if (next_pos >= 57 && next_pos <= 76) begin
      ac97_sdata_in <= codec_left[76 - next_pos];
    end else if (next_pos >= 77 && next_pos <= 96) begin
      ac97_sdata_in <= codec_right[96 - next_pos];
    end else begin
      ac97_sdata_in <= 1'b0;
    end
  end

  //////////////////////////////
  // stimulus on ready pulses
  //////////////////////////////

  always @(negedge clock_27mhz) begin
    expected_frame_t entry;
    logic [2:0]      dice;
    logic            go_up;
    if (ready === 1'b1) begin
      pulses++;
      model_step = model_step + 4'd1;
      entry.step = model_step;
      // sample held at the coming edge, tone index before its step
      entry.sample = tone_select ? sine_table[model_tone_index] : {audio_out_data, 12'h000};
      model_tone_index = model_tone_index + 6'd1;
      // volume edges settle long before the frame latch
      for (int i = 0; i < 8; i++) begin
        @(posedge clock_27mhz);
        if (i == 0) begin
          audio_out_data <= user_sample_t'(take_bits(8));
          tone_select <= (pulses >= 18 && pulses < 30);
        end
        if (i % 2 == 0) begin
          volume_up <= 1'b0;
          volume_down <= 1'b0;
        end else begin
          // up-biased, then down-biased, then even
          dice = 3'(take_bits(3));
          if (pulses <= 12) go_up = (dice != 3'd0);
          else if (pulses <= 28) go_up = (dice == 3'd0);
          else go_up = dice[0];
          volume_up <= go_up;
          volume_down <= !go_up;
          step_volume_model(go_up);
        end
      end
      entry.pair = expected_pair(model_step, model_volume);
      expected_q.push_back(entry);
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int   cycles;
    int   waited;
    int   total;
    logic released;
    reset = 1'b1;
    volume_up = 1'b0;
    volume_down = 1'b0;
    tone_select = 1'b0;
    audio_out_data = '0;
    ac97_sdata_in = 1'b0;
    for (int i = 0; i < 7; i++) begin
      @(negedge clock_27mhz);
      if (audio_reset_b !== 1'b0) report_mismatch(1, "audio_reset_b high during reset");
    end
    // eighth edge still sees reset
    @(posedge clock_27mhz);
    reset <= 1'b0;
    cycles = 0;
    released = 1'b0;
    while (!released && cycles < 2000) begin
      @(posedge clock_27mhz);
      cycles++;
      @(negedge clock_27mhz);
      released = (audio_reset_b === 1'b1);
    end
    if (!released) begin
      report_failure(1, "audio_reset_b did not rise within 2000 cycles");
    end else if (cycles != 1024) begin
      report_mismatch(1, $sformatf("audio_reset_b rose after %0d cycles, expected 1024", cycles));
    end
    $display("test 1, %s: %0d errors", test_names[1], test_errors[1]);
    waited = 0;
    while (frames_checked < frames_to_check && waited < 20000) begin
      @(posedge clock_27mhz);
      waited++;
    end
    if (frames_checked < frames_to_check) begin
      $display("timeout: only %0d frames decoded", frames_checked);
      $display("Finished with errors");
    end else begin
      if (!hit_top || !hit_bottom) report_failure(4, "volume never reached both limits");
      total = test_errors[1];
      for (int i = 2; i <= 6; i++) begin
        $display("test %0d, %s: %0d errors", i, test_names[i], test_errors[i]);
        total += test_errors[i];
      end
      $display("checks done, %0d frames, %0d errors total", frames_checked, total);
      if (total == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/ac97_pkg.sv
design/ac97_framer.sv
design/ac97_command_sequencer.sv
design/ac97_sample_port.sv
design/volume_control.sv
design/tone_generator.sv
design/ac97_audio_top.sv
testbench/tb_ac97_audio.sv

//--- run_sim.sh
#!/bin/sh
# build and run the AC97 audio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ac97_audio -f sources.f

output=$(./obj_dir/Vtb_ac97_audio)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
else
  exit 1
fi
